/* scope_top.f */
logic/acq_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/command_unit.sv
logic/acq_fsm.sv
logic/sampler.sv
logic/scope_top.sv
tests/tb_clock.sv
tests/scope_tb.sv

/* Makefile */
SOURCES := $(wildcard logic/*.sv tests/*.sv)
SIM     := obj_dir/Vscope_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): scope_top.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module scope_tb \
		-Mdir obj_dir -f scope_top.f

run: $(SIM)
	./$(SIM) > sim.log
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* tests/scope_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_decoder #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire        sys_clock,
    input  wire        i_line,
    output logic [7:0] o_byte,
    output logic       o_strobe,
    output logic       o_frame_err
);

    logic       busy   = 1'b0;
    int         cnt    = 0;
    int         bit_no = 0;
    logic [7:0] shift  = '0;

    // Line is sampled mid-bit on the falling edge.
    always @(negedge sys_clock) begin
        o_strobe    <= 1'b0;
        o_frame_err <= 1'b0;
        if (!busy) begin
            if (i_line === 1'b0) begin
                busy   <= 1'b1;
                cnt    <= 1;
                bit_no <= 0;
            end
        end else begin
            cnt <= cnt + 1;
            if (cnt == CLKS_PER_BIT * (bit_no + 1) + CLKS_PER_BIT / 2) begin
                if (bit_no < 8) begin
                    shift  <= {i_line, shift[7:1]};
                    bit_no <= bit_no + 1;
                end else begin
                    // Stop bit.
                    busy        <= 1'b0;
                    o_byte      <= shift;
                    o_strobe    <= (i_line === 1'b1);
                    o_frame_err <= (i_line !== 1'b1);
                end
            end
        end
    end

endmodule

module scope_tb
    import acq_pkg::*;
();

    localparam int CLKS_PER_BIT = 8;
    localparam int DEPTH        = 8;
    localparam int DRIVE_DLY    = 2;
    localparam int STATE_LIMIT  = 400;
    localparam int DRAIN_LIMIT  = DEPTH * CLKS_PER_BIT * 20;

    wire        sys_clock;
    wire        rst_n;
    logic       rx_line;
    logic       sample_pin;
    logic       gate;
    adc_word_t  adc;
    wire        tx_l;
    wire        tx_h;
    acq_state_e state;
    wire [7:0]  low_byte;
    wire [7:0]  high_byte;
    wire        low_strobe;
    wire        high_strobe;
    wire        low_err;
    wire        high_err;

    logic [15:0] expect_q[$];
    logic [7:0]  low_q[$];
    logic [7:0]  high_q[$];
    integer      seed;
    string       test_name = "none";
    int          test_errors   = 0;
    int          total_errors  = 0;
    int          tests_run     = 0;
    int          tests_failed  = 0;
    int          words_checked = 0;
    int          words_seen    = 0;
    bit          timed_out     = 1'b0;

    tb_clock #(
        .PERIOD       ( 40 ),
        .RESET_CYCLES ( 3  )
    ) u_clock (
        .o_sys_clock ( sys_clock ),
        .o_rst_n     ( rst_n     )
    );

    scope_top #(
        .CLKS_PER_BIT ( CLKS_PER_BIT ),
        .DEPTH        ( DEPTH        )
    ) dut (
        .sys_clock ( sys_clock  ),
        .i_rst_n   ( rst_n      ),
        .i_rx      ( rx_line    ),
        .i_sample  ( sample_pin ),
        .i_gate    ( gate       ),
        .i_adc     ( adc        ),
        .o_tx_l    ( tx_l       ),
        .o_tx_h    ( tx_h       ),
        .o_state   ( state      )
    );

    frame_decoder #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_dec_l (
        .sys_clock   ( sys_clock  ),
        .i_line      ( tx_l       ),
        .o_byte      ( low_byte   ),
        .o_strobe    ( low_strobe ),
        .o_frame_err ( low_err    )
    );

    frame_decoder #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_dec_h (
        .sys_clock   ( sys_clock   ),
        .i_line      ( tx_h        ),
        .o_byte      ( high_byte   ),
        .o_strobe    ( high_strobe ),
        .o_frame_err ( high_err    )
    );

    // Offset binary minus mid-scale as a 14-bit signed value.
    function automatic logic [15:0] expected_word(input logic [ADC_WIDTH-1:0] raw);
        logic signed [15:0] value;
        value = $signed({2'b00, raw}) - 16'sd8192;
        return {2'b00, value[ADC_WIDTH-1:0]};
    endfunction

    task automatic count_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout while waiting for %s in test %s", what, test_name);
        timed_out = 1'b1;
        count_error();
    endtask

    task automatic next_cycle();
        @(posedge sys_clock);
        #DRIVE_DLY;
    endtask

    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        int         b;
        frame = {1'b1, value, 1'b0};
        for (b = 0; b < 10; b++) begin
            next_cycle();
            rx_line = frame[b];
            repeat (CLKS_PER_BIT - 1) @(posedge sys_clock);
        end
        repeat (2 * CLKS_PER_BIT) @(posedge sys_clock);
    endtask

    task automatic wait_state(input acq_state_e want);
        int n;
        n = 0;
        @(negedge sys_clock);
        while (state != want && n < STATE_LIMIT) begin
            @(negedge sys_clock);
            n++;
        end
        if (state != want) begin
            note_timeout({"state ", want.name()});
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (expect_q.size() > 0 && n < DRAIN_LIMIT) begin
            @(negedge sys_clock);
            n++;
        end
        if (expect_q.size() > 0) begin
            note_timeout("the remaining output words");
        end
    endtask

    task automatic check_state(input acq_state_e want);
        @(negedge sys_clock);
        assert (state == want) else begin
            $display("Error: %s expected %s actual %s", test_name, want.name(), state.name());
            count_error();
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    // Drives samples until DEPTH are kept; mixed adds gate-low and invalid ones.
    task automatic capture_samples(input int decim, input bit mixed);
        int                   accepted;
        int                   kept;
        int                   pick;
        logic [ADC_WIDTH-1:0] raw;
        accepted = 0;
        kept     = 0;
        while (kept < DEPTH) begin
            raw  = ADC_WIDTH'($random(seed));
            pick = mixed ? ($random(seed) & 3) : 0;
            next_cycle();
            gate      = (pick != 1);
            adc.valid = (pick != 2);
            adc.data  = raw;
            if (pick == 0 || pick == 3) begin
                if (accepted % (decim + 1) == 0) begin
                    expect_q.push_back(expected_word(raw));
                    kept++;
                end
                accepted++;
            end
        end
        next_cycle();
        gate = 1'b0;
        adc  = '0;
    endtask

    // Gated valid samples that no expected word is recorded for.
    task automatic drive_dropped_samples(input int count);
        repeat (count) begin
            next_cycle();
            gate = 1'b1;
            adc  = {1'b1, ADC_WIDTH'($random(seed))};
        end
        next_cycle();
        gate = 1'b0;
        adc  = '0;
    endtask

    task automatic run_capture(input int decim, input bit mixed);
        wait_state(ST_CAPTURE);
        capture_samples(decim, mixed);
        wait_drained();
        wait_state(ST_IDLE);
        check_state(ST_IDLE);
    endtask

    task automatic test_reset();
        int high_cycles;
        begin_test("reset");
        high_cycles = 0;
        check_state(ST_IDLE);
        repeat (4 * CLKS_PER_BIT) begin
            @(negedge sys_clock);
            if (tx_l === 1'b1 && tx_h === 1'b1) begin
                high_cycles++;
            end
        end
        assert (high_cycles == 4 * CLKS_PER_BIT) else begin
            $display("Error: %s expected %0d idle line cycles actual %0d",
                     test_name, 4 * CLKS_PER_BIT, high_cycles);
            count_error();
        end
        end_test();
    endtask

    task automatic test_abort();
        int seen_before;
        begin_test("abort");
        seen_before = words_seen;
        send_byte(CMD_SAMPLE);
        wait_state(ST_CAPTURE);
        // Half a buffer that must never come out.
        drive_dropped_samples(DEPTH / 2);
        send_byte(CMD_RESET);
        check_state(ST_IDLE);
        // Without the abort these would fill the buffer and start a readout.
        drive_dropped_samples(DEPTH);
        repeat (3 * 10 * CLKS_PER_BIT) @(negedge sys_clock);
        assert (words_seen == seen_before) else begin
            $display("Error: %s expected %0d words actual %0d",
                     test_name, seen_before, words_seen);
            count_error();
        end
        send_byte(CMD_SAMPLE);
        run_capture(0, 1'b0);
        end_test();
    endtask

    // Compares each reassembled word with the front of the expected queue.
    always @(posedge sys_clock) begin : compare_words
        logic [15:0] got;
        logic [15:0] want;
        if (low_strobe === 1'b1) begin
            low_q.push_back(low_byte);
        end
        if (high_strobe === 1'b1) begin
            high_q.push_back(high_byte);
        end
        assert (low_err !== 1'b1 && high_err !== 1'b1) else begin
            $display("A transmit line had no valid stop bit in test %s", test_name);
            count_error();
        end
        if (low_q.size() > 0 && high_q.size() > 0) begin
            got = {high_q.pop_front(), low_q.pop_front()};
            words_seen++;
            assert (expect_q.size() > 0) else begin
                $display("Word %h arrived when none was expected in test %s", got, test_name);
                count_error();
            end
            if (expect_q.size() > 0) begin
                want = expect_q.pop_front();
                words_checked++;
                assert (got == want) else begin
                    $display("Error: %s expected %h actual %h", test_name, want, got);
                    count_error();
                end
            end
        end
    end

    initial begin
        int n;
        rx_line    = 1'b1;
        sample_pin = 1'b0;
        gate       = 1'b0;
        adc        = '0;
        seed       = 32'h3da4_f279;
        n          = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(negedge sys_clock);
            n++;
        end
        if (rst_n !== 1'b1) begin
            note_timeout("reset release");
        end

        if (!timed_out) begin
            test_reset();
        end
        if (!timed_out) begin
            begin_test("capture");
            send_byte(CMD_SAMPLE);
            run_capture(0, 1'b0);
            end_test();
        end
        if (!timed_out) begin
            begin_test("decimation");
            send_byte(CMD_DECIM);
            send_byte(8'd2);
            send_byte(CMD_SAMPLE);
            run_capture(2, 1'b0);
            send_byte(CMD_DECIM);
            send_byte(8'd0);
            end_test();
        end
        if (!timed_out) begin
            begin_test("gating");
            send_byte(CMD_SAMPLE);
            run_capture(0, 1'b1);
            end_test();
        end
        if (!timed_out) begin
            begin_test("pin_trigger");
            next_cycle();
            sample_pin = 1'b1;
            next_cycle();
            sample_pin = 1'b0;
            run_capture(0, 1'b0);
            // Unknown opcode.
            send_byte(8'h41);
            check_state(ST_IDLE);
            end_test();
        end
        if (!timed_out) begin
            test_abort();
        end

        $display("tests %0d, passed %0d, failed %0d, words checked %0d",
                 tests_run, tests_run - tests_failed, tests_failed, words_checked);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic o_sys_clock,
    output logic o_rst_n
);

    initial begin
        o_sys_clock = 1'b0;
        forever #(PERIOD / 2) o_sys_clock = ~o_sys_clock;
    end

    // Release just after the last reset edge.
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_sys_clock);
        #2 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* logic/scope_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scope_top
    import acq_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868,
    parameter int DEPTH        = 16
) (
    input  wire            sys_clock,
    input  wire            i_rst_n,
    input  wire            i_rx,
    input  wire            i_sample,
    input  wire            i_gate,
    input  wire adc_word_t i_adc,
    output wire            o_tx_l,
    output wire            o_tx_h,
    output acq_state_e     o_state
);

    wire [BYTE_WIDTH-1:0] rx_data;
    wire                  rx_valid;
    cmd_t                 cmd;
    wire                  full;
    wire                  done;
    wire                  tx_start;
    wire [15:0]           tx_word;
    wire                  tx_ready_l;
    wire                  tx_ready_h;
    wire                  tx_ready;

    // Both lines must be free before the next word.
    assign tx_ready = tx_ready_l && tx_ready_h;

    uart_rx #(
        .CLKS_PER_BIT ( CLKS_PER_BIT )
    ) u_uart_rx (
        .sys_clock    ( sys_clock    ),
        .i_rst_n      ( i_rst_n      ),
        .i_rx         ( i_rx         ),
        .o_data       ( rx_data      ),
        .o_valid      ( rx_valid     )
    );

    command_unit u_command_unit (
        .sys_clock    ( sys_clock    ),
        .i_rst_n      ( i_rst_n      ),
        .i_rx_data    ( rx_data      ),
        .i_rx_valid   ( rx_valid     ),
        .o_cmd        ( cmd          )
    );

    acq_fsm u_acq_fsm (
        .sys_clock    ( sys_clock    ),
        .i_rst_n      ( i_rst_n      ),
        .i_cmd        ( cmd          ),
        .i_sample     ( i_sample     ),
        .i_full       ( full         ),
        .i_done       ( done         ),
        .o_state      ( o_state      )
    );

    sampler #(
        .DEPTH        ( DEPTH        )
    ) u_sampler (
        .sys_clock    ( sys_clock    ),
        .i_rst_n      ( i_rst_n      ),
        .i_state      ( o_state      ),
        .i_cmd        ( cmd          ),
        .i_adc        ( i_adc        ),
        .i_gate       ( i_gate       ),
        .i_tx_ready   ( tx_ready     ),
        .o_tx_start   ( tx_start     ),
        .o_tx_word    ( tx_word      ),
        .o_full       ( full         ),
        .o_done       ( done         )
    );

    // Low byte line.
    uart_tx #(
        .CLKS_PER_BIT ( CLKS_PER_BIT )
    ) u_uart_tx_l (
        .sys_clock    ( sys_clock     ),
        .i_rst_n      ( i_rst_n       ),
        .i_start      ( tx_start      ),
        .i_data       ( tx_word[7:0]  ),
        .o_tx         ( o_tx_l        ),
        .o_ready      ( tx_ready_l    )
    );

    // High bits line with the top two bits at zero.
    uart_tx #(
        .CLKS_PER_BIT ( CLKS_PER_BIT )
    ) u_uart_tx_h (
        .sys_clock    ( sys_clock     ),
        .i_rst_n      ( i_rst_n       ),
        .i_start      ( tx_start      ),
        .i_data       ( tx_word[15:8] ),
        .o_tx         ( o_tx_h        ),
        .o_ready      ( tx_ready_h    )
    );

endmodule

`default_nettype wire

/* logic/sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module sampler
    import acq_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  wire             sys_clock,
    input  wire             i_rst_n,
    input  wire acq_state_e i_state,
    input  wire cmd_t       i_cmd,
    input  wire adc_word_t  i_adc,
    input  wire             i_gate,
    input  wire             i_tx_ready,
    output logic            o_tx_start,
    output logic [15:0]     o_tx_word,
    output logic            o_full,
    output logic            o_done
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [ADC_WIDTH-1:0]  mem [DEPTH];
    acq_state_e            state_q;
    logic [CW-1:0]         wr_cnt;
    logic [CW-1:0]         rd_cnt;
    logic [BYTE_WIDTH-1:0] decim_q;
    logic [BYTE_WIDTH-1:0] skip_cnt;

    logic                  entry;
    logic                  clear;
    logic [CW-1:0]         wr_base;
    logic [BYTE_WIDTH-1:0] skip_base;
    logic                  accept;
    logic                  keep;
    logic                  send_go;
    logic [ADC_WIDTH-1:0]  conv;

    // First cycle of a capture.
    assign entry = (i_state == ST_CAPTURE) && (state_q != ST_CAPTURE);
    assign clear = entry || i_cmd.reset;

    // Pointers start from zero in the cycle they are cleared.
    assign wr_base   = clear ? '0 : wr_cnt;
    assign skip_base = clear ? '0 : skip_cnt;

    assign accept = (i_state == ST_CAPTURE) && i_gate && i_adc.valid && !i_cmd.reset
                    && (wr_base != CW'(DEPTH));
    assign keep   = accept && (skip_base == '0);

    // Offset binary to two's complement.
    assign conv = {~i_adc.data[ADC_WIDTH-1], i_adc.data[ADC_WIDTH-2:0]};

    // Wait a cycle after each start so the transmitters can drop ready.
    assign send_go = (i_state == ST_SEND) && !i_cmd.reset && (rd_cnt != CW'(DEPTH))
                     && i_tx_ready && !o_tx_start;

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= ST_IDLE;
            wr_cnt     <= '0;
            rd_cnt     <= '0;
            skip_cnt   <= '0;
            decim_q    <= '0;
            o_tx_start <= 1'b0;
            o_full     <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            state_q    <= i_state;
            o_tx_start <= send_go;
            o_full     <= 1'b0;
            o_done     <= 1'b0;

            if (i_cmd.decim_set) begin
                decim_q <= i_cmd.decim;
            end

            // Reloading skip counter.
            if (accept) begin
                skip_cnt <= keep ? decim_q : skip_base - 1'b1;
            end else if (clear) begin
                skip_cnt <= '0;
            end

            if (keep) begin
                wr_cnt <= wr_base + 1'b1;
                o_full <= (wr_base == CW'(DEPTH - 1));
            end else if (clear) begin
                wr_cnt <= '0;
            end

            if (clear) begin
                rd_cnt <= '0;
            end else if (send_go) begin
                rd_cnt <= rd_cnt + 1'b1;
                o_done <= (rd_cnt == CW'(DEPTH - 1));
            end
        end
    end

    // Sample buffer and outgoing word.
    always_ff @(posedge sys_clock) begin
        if (keep) begin
            mem[wr_base[AW-1:0]] <= conv;
        end
        if (send_go) begin
            o_tx_word <= {{(16 - ADC_WIDTH){1'b0}}, mem[rd_cnt[AW-1:0]]};
        end
    end

endmodule

`default_nettype wire

/* logic/acq_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_fsm
    import acq_pkg::*;
(
    input  wire        sys_clock,
    input  wire        i_rst_n,
    input  wire cmd_t  i_cmd,
    input  wire        i_sample,
    input  wire        i_full,
    input  wire        i_done,
    output acq_state_e o_state
);

    acq_state_e state_q;
    acq_state_e state_d;

    assign o_state = state_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Command or pin trigger.
                if (i_cmd.sample || i_sample) begin
                    state_d = ST_CAPTURE;
                end
            end
            ST_CAPTURE: begin
                if (i_full) begin
                    state_d = ST_SEND;
                end
            end
            ST_SEND: begin
                if (i_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
        // Abort wins over everything.
        if (i_cmd.reset) begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* logic/command_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module command_unit
    import acq_pkg::*;
(
    input  wire                  sys_clock,
    input  wire                  i_rst_n,
    input  wire [BYTE_WIDTH-1:0] i_rx_data,
    input  wire                  i_rx_valid,
    output cmd_t                 o_cmd
);

    typedef enum logic {
        CU_OPCODE,
        CU_PARAM
    } cu_state_e;

    cu_state_e state;

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= CU_OPCODE;
            o_cmd <= '0;
        end else begin
            o_cmd.reset     <= 1'b0;
            o_cmd.sample    <= 1'b0;
            o_cmd.decim_set <= 1'b0;
            if (i_rx_valid) begin
                case (state)
                    CU_OPCODE: begin
                        case (cmd_op_e'(i_rx_data))
                            CMD_RESET:  o_cmd.reset  <= 1'b1;
                            CMD_SAMPLE: o_cmd.sample <= 1'b1;
                            CMD_DECIM:  state        <= CU_PARAM;
                            // Unknown bytes are dropped.
                            default: ;
                        endcase
                    end
                    CU_PARAM: begin
                        // Any byte here is the parameter even if it matches an opcode.
                        o_cmd.decim     <= i_rx_data;
                        o_cmd.decim_set <= 1'b1;
                        state           <= CU_OPCODE;
                    end
                    default: state <= CU_OPCODE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import acq_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  wire                  sys_clock,
    input  wire                  i_rst_n,
    input  wire                  i_start,
    input  wire [BYTE_WIDTH-1:0] i_data,
    output logic                 o_tx,
    output logic                 o_ready
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e             state;
    logic [CNT_W-1:0]      cnt;
    logic [2:0]            bit_idx;
    logic [BYTE_WIDTH-1:0] data_q;
    logic                  bit_end;

    assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign o_ready = (state == TX_IDLE);

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_tx    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (i_start) begin
                        o_tx  <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        o_tx    <= data_q[0];
                        state   <= TX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            o_tx    <= data_q[bit_idx + 3'd1];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    // Ready returns once the stop bit has run its full time.
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clock) begin
        if (state == TX_IDLE && i_start) begin
            data_q <= i_data;
        end
    end

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import acq_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  wire                   sys_clock,
    input  wire                   i_rst_n,
    input  wire                   i_rx,
    output logic [BYTE_WIDTH-1:0] o_data,
    output logic                  o_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int HALF  = CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e  state;
    logic [CNT_W-1:0] cnt;
    logic [2:0] bit_idx;
    logic       rx_meta;
    logic       rx_sync;
    logic       bit_end;

    assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            // Two-flop synchronizer for the line.
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck the start bit at its middle.
                    if (cnt == CNT_W'(HALF - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state   <= RX_IDLE;
                        o_valid <= rx_sync;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top.
    always_ff @(posedge sys_clock) begin
        if (state == RX_DATA && bit_end) begin
            o_data <= {rx_sync, o_data[BYTE_WIDTH-1:1]};
        end
    end

endmodule

`default_nettype wire

/* logic/acq_pkg.sv */
`default_nettype none

package acq_pkg;

    // Raw converter word and serial byte widths.
    localparam int ADC_WIDTH  = 14;
    localparam int BYTE_WIDTH = 8;

    // Command opcodes as ASCII letters.
    typedef enum logic [BYTE_WIDTH-1:0] {
        CMD_RESET  = 8'h52,
        CMD_SAMPLE = 8'h53,
        CMD_DECIM  = 8'h44
    } cmd_op_e;

    // Capture controller states that also drive the LEDs.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_SEND
    } acq_state_e;

    typedef struct packed {
        logic                 valid;
        logic [ADC_WIDTH-1:0] data;
    } adc_word_t;

    // Decoded command strobes plus the held decimation value.
    typedef struct packed {
        logic                  reset;
        logic                  sample;
        logic                  decim_set;
        logic [BYTE_WIDTH-1:0] decim;
    } cmd_t;

endpackage

`default_nettype wire
